// File: build.f
design/uart_pkg.sv
design/baud_generator.sv
design/tx_controller.sv
design/tx_shifter.sv
design/rx_controller.sv
design/rx_shifter.sv
design/uart_core.sv
testbench/uart_core_tb.sv

// File: design/baud_generator.sv
`timescale 1ns/1ps

module baud_generator #(
  parameter int unsigned CLK_FREQ   = 100000000,
  parameter int unsigned OVERSAMPLE = 16
) (
  input  logic                clk,
  input  logic                reset_n,
  input  uart_pkg::baud_sel_e cfg_baud,
  input  logic                baud_en,
  output logic                tick
);

  // Slowest rate sets the counter width.
  localparam int unsigned DIV_MAX =
    CLK_FREQ / (uart_pkg::baud_rate(uart_pkg::baud_4800) * OVERSAMPLE);
  localparam int CNT_W = $clog2(DIV_MAX + 1);

  logic [CNT_W-1:0] div_table [8];
  logic [CNT_W-1:0] divisor;
  logic [CNT_W-1:0] count;

  ////////////////////////////////////////
  // Divisor lookup
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      div_table[i] = CNT_W'(CLK_FREQ /
        (uart_pkg::baud_rate(uart_pkg::baud_sel_e'(i)) * OVERSAMPLE));
    end
  end

  always_ff @(posedge clk) begin
    divisor <= div_table[cfg_baud]; // One cycle behind the select.
  end

  ////////////////////////////////////////
  // Tick counter
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (baud_en) begin
      if (count == divisor - CNT_W'(1)) begin
        count <= '0;
        tick  <= 1'b1; // One cycle wide.
      end else begin
        count <= count + CNT_W'(1);
        tick  <= 1'b0;
      end
    end else begin
      count <= '0; // Restart on next enable.
      tick  <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // A disabled generator stays quiet.
  tick_needs_enable : assert property (
    @(posedge clk) disable iff (!reset_n)
    !$past(baud_en) |-> !tick
  );

endmodule

// File: design/rx_controller.sv
`timescale 1ns/1ps

module rx_controller (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 rx_line,
  input  uart_pkg::uart_cfg_t  cfg,
  input  logic                 tick,
  output logic                 baud_en,
  output logic                 sample,
  output logic                 clear,
  output logic                 rx_bit,
  input  logic [7:0]           data,
  input  logic                 par_acc,
  output logic                 rx_valid,
  output uart_pkg::rx_result_t rx_result
);

  uart_pkg::rx_state_e state;
  uart_pkg::uart_cfg_t cfg_q;
  logic [1:0]          rx_sync;
  logic                rx_prev;
  logic [3:0]          tick_cnt;
  logic [2:0]          bit_cnt;
  logic                par_err_q;
  logic                frame_err_q;
  logic                start_edge;
  logic                mid_bit;
  logic                stop_last;

  ////////////////////////////////////////
  // Input sync and edge detect
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rx_sync <= 2'b11;
      rx_prev <= 1'b1;
    end else begin
      rx_sync <= {rx_sync[0], rx_line};
      rx_prev <= rx_sync[1];
    end
  end

  assign rx_bit     = rx_sync[1];
  assign start_edge = (state == uart_pkg::rx_idle) && rx_prev && !rx_sync[1];
  // 8th tick in the start bit, then every 16th.
  assign mid_bit    = tick && ((state == uart_pkg::rx_start) ?
                               (tick_cnt == 4'd7) : (tick_cnt == 4'd15));
  assign baud_en    = (state != uart_pkg::rx_idle);
  assign clear      = start_edge;
  assign sample     = mid_bit && (state == uart_pkg::rx_data);
  assign stop_last  = mid_bit && (state == uart_pkg::rx_stop) &&
                      (!cfg_q.two_stop || bit_cnt[0]);

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state       <= uart_pkg::rx_idle;
      cfg_q       <= '0;
      tick_cnt    <= '0;
      bit_cnt     <= '0;
      par_err_q   <= 1'b0;
      frame_err_q <= 1'b0;
      rx_valid    <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (tick) tick_cnt <= mid_bit ? 4'd0 : tick_cnt + 4'd1;
      case (state)
        uart_pkg::rx_idle: begin
          if (start_edge) begin
            state       <= uart_pkg::rx_start;
            cfg_q       <= cfg;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            par_err_q   <= 1'b0; // Stays clear without parity.
            frame_err_q <= 1'b0;
          end
        end
        uart_pkg::rx_start: begin
          // A high start bit was a glitch.
          if (mid_bit) state <= rx_sync[1] ? uart_pkg::rx_idle : uart_pkg::rx_data;
        end
        uart_pkg::rx_data: begin
          if (mid_bit) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= (cfg_q.parity != uart_pkg::parity_none) ?
                       uart_pkg::rx_parity : uart_pkg::rx_stop;
            end
          end
        end
        uart_pkg::rx_parity: begin
          if (mid_bit) begin
            par_err_q <= (par_acc ^ rx_sync[1]) != (cfg_q.parity == uart_pkg::parity_odd);
            state     <= uart_pkg::rx_stop;
          end
        end
        uart_pkg::rx_stop: begin
          if (mid_bit) begin
            frame_err_q <= frame_err_q | !rx_sync[1];
            bit_cnt     <= bit_cnt + 3'd1;
            if (stop_last) begin
              state    <= uart_pkg::rx_idle;
              rx_valid <= 1'b1; // Middle of the last stop bit.
            end
          end
        end
        default: state <= uart_pkg::rx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (stop_last) begin
      rx_result.data       <= data;
      rx_result.parity_err <= par_err_q;
      rx_result.frame_err  <= frame_err_q | !rx_sync[1];
    end
  end

  // One pulse per frame.
  valid_single_pulse : assert property (
    @(posedge clk) disable iff (!reset_n)
    rx_valid |=> !rx_valid
  );

endmodule

// File: design/rx_shifter.sv
`timescale 1ns/1ps

module rx_shifter (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       clear,
  input  logic       sample,
  input  logic       rx_bit,
  output logic [7:0] data,
  output logic       par_acc
);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      data    <= '0;
      par_acc <= 1'b0;
    end else if (clear) begin
      data    <= '0; // New frame.
      par_acc <= 1'b0;
    end else if (sample) begin
      data    <= {rx_bit, data[7:1]}; // First bit ends up in bit 0.
      par_acc <= par_acc ^ rx_bit;
    end
  end

endmodule

// File: design/tx_controller.sv
`timescale 1ns/1ps

module tx_controller (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                tx_valid,
  output logic                tx_ready,
  input  uart_pkg::uart_cfg_t cfg,
  input  logic                tick,
  output logic                baud_en,
  output logic                load,
  output logic                shift,
  input  logic                bit_out,
  input  logic                par_bit,
  output logic                tx_line
);

  uart_pkg::tx_state_e state;
  uart_pkg::uart_cfg_t cfg_q;
  logic [2:0]          bit_cnt;
  logic                accept;

  assign tx_ready = (state == uart_pkg::tx_idle);
  assign accept   = tx_valid && tx_ready;
  assign load     = accept;
  assign shift    = tick && (state == uart_pkg::tx_data);
  assign baud_en  = !tx_ready; // Runs for the whole frame.

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state   <= uart_pkg::tx_idle;
      cfg_q   <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        uart_pkg::tx_idle: begin
          if (accept) begin
            state   <= uart_pkg::tx_start;
            cfg_q   <= cfg; // Held for the frame.
            bit_cnt <= '0;
          end
        end
        uart_pkg::tx_start: begin
          if (tick) state <= uart_pkg::tx_data;
        end
        uart_pkg::tx_data: begin
          if (tick) begin
            bit_cnt <= bit_cnt + 3'd1; // Wraps to 0 for the stop count.
            if (bit_cnt == 3'd7) begin
              state <= (cfg_q.parity != uart_pkg::parity_none) ?
                       uart_pkg::tx_parity : uart_pkg::tx_stop;
            end
          end
        end
        uart_pkg::tx_parity: begin
          if (tick) state <= uart_pkg::tx_stop;
        end
        uart_pkg::tx_stop: begin
          if (tick) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (!cfg_q.two_stop || bit_cnt[0]) state <= uart_pkg::tx_idle;
          end
        end
        default: state <= uart_pkg::tx_idle;
      endcase
    end
  end

  // Line level per bit.
  always_comb begin
    case (state)
      uart_pkg::tx_start:  tx_line = 1'b0;
      uart_pkg::tx_data:   tx_line = bit_out;
      uart_pkg::tx_parity: tx_line = par_bit;
      default:             tx_line = 1'b1; // Idle and stop.
    endcase
  end

  // Line rests high between frames.
  idle_line_high : assert property (
    @(posedge clk) disable iff (!reset_n)
    tx_ready |-> tx_line
  );

endmodule

// File: design/tx_shifter.sv
`timescale 1ns/1ps

module tx_shifter (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              load,
  input  logic              shift,
  input  logic [7:0]        tx_data,
  input  uart_pkg::parity_e parity,
  output logic              bit_out,
  output logic              par_bit
);

  logic [7:0] shift_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      shift_q <= 8'hff;
      par_bit <= 1'b0;
    end else if (load) begin
      shift_q <= tx_data;
      // Odd mode inverts the XOR.
      par_bit <= (^tx_data) ^ (parity == uart_pkg::parity_odd);
    end else if (shift) begin
      shift_q <= {1'b1, shift_q[7:1]}; // LSB first.
    end
  end

  assign bit_out = shift_q[0];

endmodule

// File: design/uart_core.sv
`timescale 1ns/1ps

module uart_core #(
  parameter int unsigned CLK_FREQ = 100000000
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  uart_pkg::uart_cfg_t  cfg,
  input  logic                 tx_valid,
  output logic                 tx_ready,
  input  logic [7:0]           tx_data,
  output logic                 tx_line,
  input  logic                 rx_line,
  output logic                 rx_valid,
  output uart_pkg::rx_result_t rx_result
);

  logic       tx_baud_en;
  logic       tx_tick;
  logic       tx_load;
  logic       tx_shift;
  logic       tx_bit;
  logic       tx_par_bit;
  logic       rx_baud_en;
  logic       rx_tick;
  logic       rx_sample;
  logic       rx_clear;
  logic       rx_bit;
  logic [7:0] rx_data;
  logic       rx_par_acc;

  ////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////

  baud_generator #(.CLK_FREQ(CLK_FREQ), .OVERSAMPLE(1)) u_tx_baud (
    .clk      (clk),
    .reset_n  (reset_n),
    .cfg_baud (cfg.baud_sel),
    .baud_en  (tx_baud_en),
    .tick     (tx_tick)
  );

  tx_controller u_tx_ctrl (
    .clk      (clk),
    .reset_n  (reset_n),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .cfg      (cfg),
    .tick     (tx_tick),
    .baud_en  (tx_baud_en),
    .load     (tx_load),
    .shift    (tx_shift),
    .bit_out  (tx_bit),
    .par_bit  (tx_par_bit),
    .tx_line  (tx_line)
  );

  tx_shifter u_tx_shift (
    .clk     (clk),
    .reset_n (reset_n),
    .load    (tx_load),
    .shift   (tx_shift),
    .tx_data (tx_data),
    .parity  (cfg.parity), // Latched on load.
    .bit_out (tx_bit),
    .par_bit (tx_par_bit)
  );

  ////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////

  baud_generator #(.CLK_FREQ(CLK_FREQ), .OVERSAMPLE(16)) u_rx_baud (
    .clk      (clk),
    .reset_n  (reset_n),
    .cfg_baud (cfg.baud_sel),
    .baud_en  (rx_baud_en),
    .tick     (rx_tick)
  );

  rx_controller u_rx_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .rx_line   (rx_line),
    .cfg       (cfg),
    .tick      (rx_tick),
    .baud_en   (rx_baud_en),
    .sample    (rx_sample),
    .clear     (rx_clear),
    .rx_bit    (rx_bit),
    .data      (rx_data),
    .par_acc   (rx_par_acc),
    .rx_valid  (rx_valid),
    .rx_result (rx_result)
  );

  rx_shifter u_rx_shift (
    .clk     (clk),
    .reset_n (reset_n),
    .clear   (rx_clear),
    .sample  (rx_sample),
    .rx_bit  (rx_bit),
    .data    (rx_data),
    .par_acc (rx_par_acc)
  );

endmodule

// File: design/uart_pkg.sv
package uart_pkg;

  typedef enum logic [2:0] {
    baud_4800,
    baud_9600,
    baud_14400,
    baud_19200,
    baud_38400,
    baud_57600,
    baud_115200,
    baud_230400
  } baud_sel_e;

  typedef enum logic [1:0] {
    parity_none,
    parity_even,
    parity_odd
  } parity_e;

  typedef struct packed {
    baud_sel_e baud_sel;
    parity_e   parity;
    logic      two_stop;
  } uart_cfg_t;

  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
  } rx_result_t;

  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_parity,
    tx_stop
  } tx_state_e;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_e;

  // Bits per second for each select code.
  function automatic int unsigned baud_rate(baud_sel_e sel);
    case (sel)
      baud_4800:   return 4800;
      baud_9600:   return 9600;
      baud_14400:  return 14400;
      baud_19200:  return 19200;
      baud_38400:  return 38400;
      baud_57600:  return 57600;
      baud_115200: return 115200;
      baud_230400: return 230400;
      default:     return 115200;
    endcase
  endfunction

endpackage

// File: testbench/uart_core_tb.sv
`timescale 1ns/1ps

module uart_core_tb;

  localparam int unsigned CLK_FREQ      = 3686400; // Whole divisors at every rate.
  localparam logic [1:0]  MODE_LOOP     = 2'd0;
  localparam logic [1:0]  MODE_BAD_PAR  = 2'd1;
  localparam logic [1:0]  MODE_BAD_STOP = 2'd2;

  typedef struct packed {
    uart_pkg::uart_cfg_t  cfg;
    logic [1:0]           mode;
    uart_pkg::rx_result_t result; // Expected receive result.
  } pattern_t;

  logic                 clk;
  logic                 reset_n;
  uart_pkg::uart_cfg_t  cfg;
  logic                 tx_valid;
  logic                 tx_ready;
  logic [7:0]           tx_data;
  logic                 tx_line;
  logic                 rx_line;
  logic                 gen_line;
  logic                 loop_mode;
  logic                 rx_valid;
  uart_pkg::rx_result_t rx_result;

  pattern_t             patterns[$];
  string                names[$];
  uart_pkg::rx_result_t rx_seen[$];
  int                   errors;
  bit                   loaded;

  assign rx_line = loop_mode ? tx_line : gen_line;

  uart_core #(.CLK_FREQ(CLK_FREQ)) uut (
    .clk       (clk),
    .reset_n   (reset_n),
    .cfg       (cfg),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .tx_data   (tx_data),
    .tx_line   (tx_line),
    .rx_line   (rx_line),
    .rx_valid  (rx_valid),
    .rx_result (rx_result)
  );

  always #20 clk = ~clk;

  // Every receive pulse lands here.
  always @(posedge clk) begin
    #1;
    if (reset_n && rx_valid) rx_seen.push_back(rx_result);
  end

  ////////////////////////////////////////
  // Frame model
  ////////////////////////////////////////

  function automatic int bit_clocks(uart_pkg::baud_sel_e sel);
    return CLK_FREQ / uart_pkg::baud_rate(sel);
  endfunction

  function automatic int frame_len(uart_pkg::uart_cfg_t c);
    return 10 + int'(c.parity != uart_pkg::parity_none) + int'(c.two_stop);
  endfunction

  // Line levels in send order, start bit in bit 0.
  function automatic logic [11:0] frame_bits(uart_pkg::uart_cfg_t c, logic [7:0] d);
    logic [11:0] f;
    f = {3'b111, d, 1'b0};
    if (c.parity == uart_pkg::parity_even) f[9] = ^d;
    if (c.parity == uart_pkg::parity_odd) f[9] = ~^d;
    return f;
  endfunction

  task automatic report_err(string name, string what, logic [15:0] exp, logic [15:0] act);
    errors++;
    $display("ERR %s %s: expected %0h actual %0h", name, what, exp, act);
  endtask

  task automatic load_patterns();
    int       fd;
    int       b, p, s, d, pe, fe;
    string    line, name, mode;
    pattern_t pat;
    fd = $fopen("testbench/uart_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/uart_patterns.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      if ($sscanf(line, "%s %d %d %d %h %s %d %d", name, b, p, s, d, mode, pe, fe) != 8) begin
        $display("Malformed pattern line: %s", line);
        errors++;
        continue;
      end
      pat.cfg.baud_sel = uart_pkg::baud_sel_e'(b);
      pat.cfg.parity   = uart_pkg::parity_e'(p);
      pat.cfg.two_stop = s[0];
      pat.mode   = (mode == "bad_parity") ? MODE_BAD_PAR :
                   (mode == "bad_stop") ? MODE_BAD_STOP : MODE_LOOP;
      pat.result = {d[7:0], pe[0], fe[0]};
      patterns.push_back(pat);
      names.push_back(name);
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // Test steps
  ////////////////////////////////////////

  // Quiet line check, ends 2 ns after an edge.
  task automatic idle_gap(string name, int cycles);
    int i;
    for (i = 0; i < cycles; i++) begin
      @(posedge clk);
      #1;
      if (tx_line !== 1'b1) report_err(name, "idle tx_line", 1, tx_line);
      if (tx_ready !== 1'b1) report_err(name, "idle tx_ready", 1, tx_ready);
      #1;
    end
  endtask

  task automatic check_rx(string name, uart_pkg::rx_result_t exp, int limit);
    uart_pkg::rx_result_t got;
    int                   c;
    c = 0;
    while (rx_seen.size() == 0 && c < limit) begin
      @(posedge clk);
      #2;
      c++;
    end
    if (rx_seen.size() == 0) begin
      $display("No receive pulse arrived for test %s", name);
      errors++;
    end else begin
      got = rx_seen.pop_front();
      if (got !== exp) report_err(name, "rx_result", exp, got);
    end
  endtask

  task automatic run_loop(string name, pattern_t p);
    int          d, n, k, hold, end_cyc;
    logic [11:0] f;
    d       = bit_clocks(p.cfg.baud_sel);
    n       = frame_len(p.cfg);
    f       = frame_bits(p.cfg, p.result.data);
    end_cyc = n * d + 1;
    hold    = n * d - $urandom % 8; // tx_valid stays up this long after acceptance.
    tx_data  = p.result.data;
    tx_valid = 1'b1;
    while (tx_ready !== 1'b1) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk); // Acceptance edge.
    for (k = 0; k <= end_cyc; k++) begin
      if (k > 0) @(posedge clk);
      #1;
      if (tx_ready !== (k == end_cyc))
        report_err(name, $sformatf("tx_ready at cycle %0d", k), k == end_cyc, tx_ready);
      if (k % d == d / 2 && k < n * d && tx_line !== f[k / d])
        report_err(name, $sformatf("tx_line bit %0d", k / d), f[k / d], tx_line);
      #1;
      if (k == hold) tx_valid = 1'b0;
    end
    check_rx(name, p.result, 2 * d);
  endtask

  task automatic run_generated(string name, pattern_t p);
    int          d, n, i, c;
    logic [11:0] f;
    d = bit_clocks(p.cfg.baud_sel);
    n = frame_len(p.cfg);
    f = frame_bits(p.cfg, p.result.data);
    if (p.mode == MODE_BAD_PAR) f[9] = ~f[9];
    else f[9 + int'(p.cfg.parity != uart_pkg::parity_none)] = 1'b0; // First stop bit.
    for (i = 0; i < n; i++) begin
      gen_line = f[i];
      for (c = 0; c < d; c++) begin
        @(posedge clk);
        #1;
        if (tx_line !== 1'b1) report_err(name, "idle tx_line", 1, tx_line);
        #1;
      end
    end
    gen_line = 1'b1;
    check_rx(name, p.result, 2 * d);
  endtask

  initial begin
    int idx;
    void'($urandom(32'h18b244ff));
    clk       = 1'b0;
    reset_n   = 1'b0;
    cfg       = '0;
    tx_valid  = 1'b0;
    tx_data   = 8'h00;
    gen_line  = 1'b1;
    loop_mode = 1'b1;
    errors    = 0;
    load_patterns();
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    reset_n = 1'b1;
    @(posedge clk);
    #1;
    if (tx_line !== 1'b1) report_err("reset", "tx_line", 1, tx_line);
    if (tx_ready !== 1'b1) report_err("reset", "tx_ready", 1, tx_ready);
    if (rx_valid !== 1'b0) report_err("reset", "rx_valid", 0, rx_valid);
    if (uut.tx_baud_en !== 1'b0) report_err("reset", "tx baud_en", 0, uut.tx_baud_en);
    if (uut.rx_baud_en !== 1'b0) report_err("reset", "rx baud_en", 0, uut.rx_baud_en);
    #1;
    for (idx = 0; idx < patterns.size(); idx++) begin
      cfg       = patterns[idx].cfg;
      loop_mode = (patterns[idx].mode == MODE_LOOP);
      idle_gap(names[idx], 4 + $urandom % 32);
      if (rx_seen.size() != 0) begin
        $display("rx_valid pulsed on an idle line before test %s", names[idx]);
        errors++;
        rx_seen.delete();
      end
      if (loop_mode) run_loop(names[idx], patterns[idx]);
      else run_generated(names[idx], patterns[idx]);
    end
    idle_gap("final", 32);
    if (rx_seen.size() != 0) begin
      $display("rx_valid pulsed on an idle line after the last test");
      errors++;
    end
    $display("Tests run: %0d, errors: %0d", patterns.size(), errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Three longest 4800 baud frames per pattern.
  initial begin
    longint limit;
    wait (loaded);
    limit = longint'(patterns.size()) * 12 * bit_clocks(uart_pkg::baud_4800) * 3;
    repeat (limit + 64) @(posedge clk);
    $display("The run timed out after %0d clock cycles", limit + 64);
    $display("Tests run: %0d, errors: %0d", patterns.size(), errors);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: testbench/uart_patterns.txt
# name baud_sel parity two_stop data mode parity_err frame_err
# baud_sel 0..7 is 4800 up to 230400; parity 0 none, 1 even, 2 odd; data in hex
loop_4800_8n1        0 0 0 a5 loop 0 0
loop_9600_8e1        1 1 0 3c loop 0 0
loop_14400_8o1       2 2 0 81 loop 0 0
loop_19200_8n2       3 0 1 7e loop 0 0
loop_38400_8e2       4 1 1 00 loop 0 0
loop_57600_8o2       5 2 1 ff loop 0 0
loop_115200_8n1      6 0 0 55 loop 0 0
loop_230400_8e1      7 1 0 aa loop 0 0
loop_230400_8o1      7 2 0 01 loop 0 0
loop_230400_8n2      7 0 1 80 loop 0 0
loop_115200_8e2      6 1 1 c3 loop 0 0
loop_115200_8o2      6 2 1 96 loop 0 0
loop_4800_8o2        0 2 1 e7 loop 0 0
bad_par_even_57600   5 1 0 5a bad_parity 1 0
bad_par_odd_115200   6 2 0 3f bad_parity 1 0
bad_par_even_230400  7 1 1 00 bad_parity 1 0
bad_stop_8n1_115200  6 0 0 42 bad_stop 0 1
bad_stop_8e1_230400  7 1 0 99 bad_stop 0 1
bad_stop_8n2_57600   5 0 1 f0 bad_stop 0 1
bad_stop_8o2_38400   4 2 1 0f bad_stop 0 1
loop_230400_8e2      7 1 1 6d loop 0 0
